// ==== verilog/fabric_cfg.svh ====
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// one cache line, four 32-bit words
`define FAB_LINE_W 128

// byte address as the core issues it
`define FAB_ADDR_W 64

// lines held by the on-chip line memory
`define FAB_MEM_LINES 64

// clock edges from acceptance to the ready pulse
`define FAB_MEM_LATENCY 3

// word width used by the reset fill pattern
`define FAB_WORD_W 32

`endif

// ==== verilog/fabric_pkg.sv ====
`include "fabric_cfg.svh"

package fabric_pkg;

    // one full refill line
    typedef logic [`FAB_LINE_W-1:0] line_t;

    // byte address, line index sits just above the 16-byte offset
    typedef logic [`FAB_ADDR_W-1:0] addr_t;

    // bus ownership as the arbiter tracks it
    typedef enum logic [1:0] {
        GNT_IDLE   = 2'b00, // nobody owns mbus
        GNT_ICACHE = 2'b01, // instruction refill
        GNT_DCACHE = 2'b10  // data refill or writeback
    } grant_e;

endpackage

// ==== verilog/line_bus_if.sv ====
`timescale 1ns/1ps

interface line_bus_if;

    import fabric_pkg::*;

    addr_t addr;  // byte address of the line
    logic  write; // 1 = store wdata, 0 = fetch
    logic  valid; // held until ready
    line_t wdata; // store data, only meaningful with write
    line_t rdata; // fetched line, good only while ready
    logic  ready; // single-cycle completion pulse

    // requester side
    modport client (
        output addr,
        output write,
        output valid,
        output wdata,
        input  rdata,
        input  ready
    );

    // arbiter facing a cache
    modport arb (
        input  addr,
        input  write,
        input  valid,
        input  wdata,
        output rdata,
        output ready
    );

    // memory side of the shared bus
    modport mem (
        input  addr,
        input  write,
        input  valid,
        input  wdata,
        output rdata,
        output ready
    );

endinterface

// ==== verilog/line_arbiter.sv ====
`timescale 1ns/1ps

module line_arbiter (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_acq_i, // icache wants the bus
    input  logic       d_acq_i, // dcache wants the bus
    line_bus_if.arb    ibus,
    line_bus_if.arb    dbus,
    line_bus_if.client mbus
);

    import fabric_pkg::*;

    grant_e gnt_q; // current owner
    grant_e gnt_d;

    logic i_own; // decoded grant
    logic d_own;

    // ownership register
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_q <= GNT_IDLE;
        end else begin
            gnt_q <= gnt_d;
        end
    end

    // dcache first from idle and the owner keeps it
    // until its acquire drops
    always_comb begin
        gnt_d = gnt_q;
        unique case (gnt_q)
            GNT_IDLE: begin
                if (d_acq_i) begin
                    gnt_d = GNT_DCACHE;
                end else if (i_acq_i) begin
                    gnt_d = GNT_ICACHE;
                end else begin
                    gnt_d = GNT_IDLE;
                end
            end
            GNT_DCACHE: begin
                gnt_d = d_acq_i ? GNT_DCACHE : GNT_IDLE; // release on low acquire
            end
            GNT_ICACHE: begin
                gnt_d = i_acq_i ? GNT_ICACHE : GNT_IDLE;
            end
            default: begin
                gnt_d = GNT_IDLE; // unused encoding
            end
        endcase
    end

    assign i_own = (gnt_q == GNT_ICACHE);
    assign d_own = (gnt_q == GNT_DCACHE);

    // owner's request fields onto mbus
    always_comb begin
        if (d_own) begin
            mbus.addr  = dbus.addr;
            mbus.write = dbus.write;
            mbus.valid = dbus.valid;
        end else if (i_own) begin
            mbus.addr  = ibus.addr;
            mbus.write = ibus.write; // tied low at top
            mbus.valid = ibus.valid;
        end else begin
            mbus.addr  = '0;
            mbus.write = 1'b0;
            mbus.valid = 1'b0; // idle bus never requests
        end
    end

    // only dcache ever stores
    assign mbus.wdata = dbus.wdata;

    // response side
    assign ibus.rdata = mbus.rdata; // broadcast since ready qualifies it
    assign dbus.rdata = mbus.rdata;
    assign ibus.ready = i_own & mbus.ready; // non-owner sees nothing
    assign dbus.ready = d_own & mbus.ready;

    // a completion goes to exactly one client
    a_one_ready : assert property (
        @(posedge clk) disable iff (rst)
        !(ibus.ready && dbus.ready)
    ) else $error("line_arbiter: both readies high");

    // no stray request on the shared bus without an owner
    a_idle_quiet : assert property (
        @(posedge clk) disable iff (rst)
        (gnt_q == GNT_IDLE) |-> !mbus.valid
    ) else $error("line_arbiter: mbus valid with no owner");

    // owner keeps the bus while its access is still in flight
    a_hold_grant : assert property (
        @(posedge clk) disable iff (rst)
        (gnt_q != GNT_IDLE && mbus.valid && !mbus.ready) |=> (gnt_q == $past(gnt_q))
    ) else $error("line_arbiter: grant lost mid-access");

endmodule

// ==== verilog/line_mem.sv ====
`timescale 1ns/1ps
`include "fabric_cfg.svh"

module line_mem (
    input  logic    clk,
    input  logic    rst,
    line_bus_if.mem mbus
);

    import fabric_pkg::*;

    localparam int IDX_W  = $clog2(`FAB_MEM_LINES);
    localparam int CNT_W  = $clog2(`FAB_MEM_LATENCY + 1);
    localparam int WORDS  = `FAB_LINE_W / `FAB_WORD_W;

    typedef enum logic [1:0] {
        MEM_IDLE = 2'b00, // waiting for valid
        MEM_BUSY = 2'b01, // latency countdown
        MEM_DONE = 2'b10  // ready pulse cycle
    } mem_state_e;

    mem_state_e state_q;
    logic [CNT_W-1:0] cnt_q;  // edges left before done
    logic             rest_q; // one dead cycle after done

    logic [IDX_W-1:0] idx_q;   // latched line index
    logic             write_q; // latched direction
    line_t            wdata_q; // latched store data
    line_t            rdata_q; // fetched line for the done cycle

    line_t mem_q [`FAB_MEM_LINES]; // line storage

    logic accept; // take a request this edge
    logic finish; // countdown hits zero this edge

    assign accept = (state_q == MEM_IDLE) && !rest_q && mbus.valid;
    assign finish = (state_q == MEM_BUSY) && (cnt_q == '0);

    // sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= MEM_IDLE;
            cnt_q   <= '0;
            rest_q  <= 1'b0;
        end else begin
            unique case (state_q)
                MEM_IDLE: begin
                    rest_q <= 1'b0; // clears after one idle cycle
                    if (accept) begin
                        state_q <= MEM_BUSY;
                        cnt_q   <= CNT_W'(`FAB_MEM_LATENCY - 1);
                    end
                end
                MEM_BUSY: begin
                    if (finish) begin
                        state_q <= MEM_DONE;
                    end else begin
                        cnt_q <= cnt_q - CNT_W'(1);
                    end
                end
                MEM_DONE: begin
                    state_q <= MEM_IDLE; // ready is one cycle only
                    rest_q  <= 1'b1;
                end
                default: begin
                    state_q <= MEM_IDLE;
                end
            endcase
        end
    end

    // latch the request on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q   <= mbus.addr[4 +: IDX_W]; // low 4 bits are the byte offset
            write_q <= mbus.write;
            wdata_q <= mbus.wdata;
        end
    end

    // storage with pattern fill during reset
    // line n reads back as n in every word
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int unsigned n = 0; n < `FAB_MEM_LINES; n++) begin
                mem_q[n] <= {WORDS{`FAB_WORD_W'(n)}};
            end
        end else if (finish && write_q) begin
            mem_q[idx_q] <= wdata_q; // lands as ready rises
        end
    end

    // read data for the done cycle
    always_ff @(posedge clk) begin
        if (finish) begin
            rdata_q <= write_q ? wdata_q : mem_q[idx_q]; // store echoes its data
        end
    end

    assign mbus.ready = (state_q == MEM_DONE);
    assign mbus.rdata = rdata_q;

    // ready is a single-cycle pulse
    a_ready_pulse : assert property (
        @(posedge clk) disable iff (rst)
        mbus.ready |=> !mbus.ready
    ) else $error("line_mem: ready longer than one cycle");

    // requester must hold its request for the whole access
    a_valid_held : assert property (
        @(posedge clk) disable iff (rst)
        (state_q == MEM_BUSY) |-> mbus.valid
    ) else $error("line_mem: valid dropped while busy");

endmodule

// ==== verilog/cache_mem_fabric.sv ====
`timescale 1ns/1ps

module cache_mem_fabric (
    input  logic              clk,
    input  logic              rst,

    // icache refill port, read only
    input  logic              i_acq_i,
    input  fabric_pkg::addr_t i_addr_i,
    input  logic              i_valid_i,
    output fabric_pkg::line_t i_rdata_o,
    output logic              i_ready_o,

    // dcache refill and writeback port
    input  logic              d_acq_i,
    input  fabric_pkg::addr_t d_addr_i,
    input  logic              d_write_i,
    input  logic              d_valid_i,
    input  fabric_pkg::line_t d_wdata_i,
    output fabric_pkg::line_t d_rdata_o,
    output logic              d_ready_o
);

    line_bus_if ibus (); // icache to arbiter
    line_bus_if dbus (); // dcache to arbiter
    line_bus_if mbus (); // arbiter to memory

    // icache side
    assign ibus.addr  = i_addr_i;
    assign ibus.write = 1'b0; // never stores
    assign ibus.valid = i_valid_i;
    assign ibus.wdata = '0;
    assign i_rdata_o  = ibus.rdata;
    assign i_ready_o  = ibus.ready;

    // dcache side
    assign dbus.addr  = d_addr_i;
    assign dbus.write = d_write_i;
    assign dbus.valid = d_valid_i;
    assign dbus.wdata = d_wdata_i;
    assign d_rdata_o  = dbus.rdata;
    assign d_ready_o  = dbus.ready;

    // owner selection and steering
    line_arbiter u_line_arbiter (
        .clk     (clk),
        .rst     (rst),
        .i_acq_i (i_acq_i),
        .d_acq_i (d_acq_i),
        .ibus    (ibus.arb),
        .dbus    (dbus.arb),
        .mbus    (mbus.client)
    );

    // backing store behind the shared bus
    line_mem u_line_mem (
        .clk  (clk),
        .rst  (rst),
        .mbus (mbus.mem)
    );

endmodule

// ==== dv/cache_mem_fabric_tb.sv ====
`timescale 1ns/1ps
`include "fabric_cfg.svh"

module cache_mem_fabric_tb;

    import fabric_pkg::*;

    localparam int LAT        = `FAB_MEM_LATENCY;
    localparam int LINES      = `FAB_MEM_LINES;
    localparam int IDX_W      = $clog2(`FAB_MEM_LINES);
    localparam int WORDS      = `FAB_LINE_W / 32;
    localparam int RST_CYCLES = 3;
    localparam int WAIT_LIMIT = 4 * (LAT + 6); // generous bound for one ready
    // 4 reset reads, 3 write/read, 2 priority, 4 sticky, 40 random
    localparam int NUM_ACCESSES   = 53;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_ACCESSES * WAIT_LIMIT + RST_CYCLES);

    logic  clk;
    logic  rst;
    logic  i_acq;
    addr_t i_addr;
    logic  i_valid;
    line_t i_rdata;
    logic  i_ready;
    logic  d_acq;
    addr_t d_addr;
    logic  d_write;
    logic  d_valid;
    line_t d_wdata;
    line_t d_rdata;
    logic  d_ready;

    line_t ref_mem [LINES]; // expected memory contents
    int    cycle_cnt = 0;

    cache_mem_fabric u_cache_mem_fabric (
        .clk       (clk),
        .rst       (rst),
        .i_acq_i   (i_acq),
        .i_addr_i  (i_addr),
        .i_valid_i (i_valid),
        .i_rdata_o (i_rdata),
        .i_ready_o (i_ready),
        .d_acq_i   (d_acq),
        .d_addr_i  (d_addr),
        .d_write_i (d_write),
        .d_valid_i (d_valid),
        .d_wdata_i (d_wdata),
        .d_rdata_o (d_rdata),
        .d_ready_o (d_ready)
    );

    always #50 clk = ~clk; // 100 ns period

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
            fail_run();
        end
    endtask

    // byte address of a line, offset bits don't select anything
    function automatic addr_t addr_of(input int unsigned idx, input logic [3:0] off);
        return (addr_t'(idx) << 4) | addr_t'(off);
    endfunction

    function automatic int unsigned line_of(input addr_t a);
        return int'(a[4 +: IDX_W]);
    endfunction

    task automatic drive_icache(input logic acq, input logic valid, input addr_t addr);
        i_acq   <= acq;
        i_valid <= valid;
        i_addr  <= addr;
    endtask

    task automatic drive_dcache(input logic acq, input logic valid, input logic wr,
                                input addr_t addr, input line_t wdata);
        d_acq   <= acq;
        d_valid <= valid;
        d_write <= wr;
        d_addr  <= addr;
        d_wdata <= wdata;
    endtask

    // edge by edge until the client sees ready, other side must stay quiet
    task automatic wait_ready(input string name, input logic on_d, output line_t rdata);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            n++;
            check_bit(name, 1'b0, on_d ? i_ready : d_ready); // non-owner never sees ready
            if (on_d ? d_ready : i_ready) begin
                seen = 1'b1;
            end else if (n >= WAIT_LIMIT) begin
                $display("%s: no ready for the %s within %0d cycles",
                         name, on_d ? "dcache" : "icache", WAIT_LIMIT);
                fail_run();
            end
        end
        rdata = on_d ? d_rdata : i_rdata; // only good in the ready cycle
    endtask

    // one full access from a single client
    task automatic do_access(input string name, input logic on_d, input logic wr,
                             input addr_t addr, input line_t wdata, input logic keep_acq,
                             output line_t rdata);
        @(posedge clk);
        if (on_d) begin
            drive_dcache(1'b1, 1'b1, wr, addr, wdata);
        end else begin
            drive_icache(1'b1, 1'b1, addr);
        end
        wait_ready(name, on_d, rdata);
        if (on_d) begin
            drive_dcache(keep_acq, 1'b0, 1'b0, addr, '0); // valid drops on the ready edge
        end else begin
            drive_icache(keep_acq, 1'b0, addr);
        end
    endtask

    // exact latency from an idle fabric
    task automatic test_reset_read();
        int unsigned lines [4] = '{0, 5, 37, 63};
        foreach (lines[k]) begin
            @(posedge clk);
            drive_icache(1'b1, 1'b1, addr_of(lines[k], 4'(k * 5)));
            repeat (LAT + 2) begin
                @(posedge clk);
                check_bit("test_reset_read", 1'b0, i_ready);
            end
            @(posedge clk);
            check_bit("test_reset_read", 1'b1, i_ready);
            check_line("test_reset_read", ref_mem[lines[k]], i_rdata);
            drive_icache(1'b0, 1'b0, '0);
        end
    endtask

    task automatic test_write_read();
        line_t rd;
        line_t wd;
        wd = 128'hfeed_0c0f_fee0_1234_5678_9abc_def0_4242;
        do_access("test_write_read", 1'b1, 1'b1, addr_of(12, 4'h0), wd, 1'b0, rd);
        ref_mem[12] = wd;
        do_access("test_write_read", 1'b1, 1'b0, addr_of(12, 4'h8), '0, 1'b0, rd);
        check_line("test_write_read", ref_mem[12], rd);
        do_access("test_write_read", 1'b0, 1'b0, addr_of(12, 4'hf), '0, 1'b0, rd);
        check_line("test_write_read", ref_mem[12], rd);
    endtask

    // same-edge acquire, dcache goes first
    task automatic test_priority();
        line_t rd;
        @(posedge clk);
        drive_icache(1'b1, 1'b1, addr_of(20, 4'h0));
        drive_dcache(1'b1, 1'b1, 1'b0, addr_of(21, 4'h0), '0);
        wait_ready("test_priority", 1'b1, rd); // also checks i_ready low
        check_line("test_priority", ref_mem[21], rd);
        drive_dcache(1'b0, 1'b0, 1'b0, '0, '0);
        wait_ready("test_priority", 1'b0, rd);
        check_line("test_priority", ref_mem[20], rd);
        drive_icache(1'b0, 1'b0, '0);
    endtask

    // icache keeps its grant over three reads, dcache waits
    task automatic test_sticky_grant();
        line_t rd;
        @(posedge clk);
        drive_icache(1'b1, 1'b1, addr_of(30, 4'h0));
        @(posedge clk);
        drive_dcache(1'b1, 1'b1, 1'b0, addr_of(40, 4'h4), '0); // one edge late
        wait_ready("test_sticky_grant", 1'b0, rd);
        check_line("test_sticky_grant", ref_mem[30], rd);
        drive_icache(1'b1, 1'b0, '0); // grant held
        do_access("test_sticky_grant", 1'b0, 1'b0, addr_of(31, 4'h0), '0, 1'b1, rd);
        check_line("test_sticky_grant", ref_mem[31], rd);
        do_access("test_sticky_grant", 1'b0, 1'b0, addr_of(12, 4'h0), '0, 1'b0, rd);
        check_line("test_sticky_grant", ref_mem[12], rd);
        wait_ready("test_sticky_grant", 1'b1, rd); // dcache only now
        check_line("test_sticky_grant", ref_mem[40], rd);
        drive_dcache(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic        on_d;
        logic        wr;
        addr_t       addr;
        line_t       wd;
        line_t       rd;
        string       name;
        for (int k = 0; k < 40; k++) begin
            r    = $urandom;
            on_d = r[0];
            wr   = on_d & r[1]; // only dcache stores
            addr = addr_of(r[31:8] % LINES, r[7:4]);
            wd   = {$urandom, $urandom, $urandom, $urandom};
            name = $sformatf("test_random[%0d]", k);
            do_access(name, on_d, wr, addr, wd, 1'b0, rd);
            if (wr) begin
                ref_mem[line_of(addr)] = wd;
            end else begin
                check_line(name, ref_mem[line_of(addr)], rd);
            end
        end
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        i_acq   = 1'b0;
        i_addr  = '0;
        i_valid = 1'b0;
        d_acq   = 1'b0;
        d_addr  = '0;
        d_write = 1'b0;
        d_valid = 1'b0;
        d_wdata = '0;
        void'($urandom(32'hc9f2));
        // reset contents, every word of line n is n
        for (int unsigned n = 0; n < LINES; n++) begin
            ref_mem[n] = {WORDS{32'(n)}};
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_reset_read();
        test_write_read();
        test_priority();
        test_sticky_grant();
        test_random();

        repeat (2) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== cache_mem_fabric.f ====
+incdir+verilog
verilog/fabric_pkg.sv
verilog/line_bus_if.sv
verilog/line_arbiter.sv
verilog/line_mem.sv
verilog/cache_mem_fabric.sv
dv/cache_mem_fabric_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fabric testbench with Verilator
# the exit status of the simulation is the verdict

cd "$(dirname "$0")" &&
verilator --binary --assert \
    -f cache_mem_fabric.f \
    --top-module cache_mem_fabric_tb \
    -o cache_mem_fabric_sim &&
./obj_dir/cache_mem_fabric_sim || {
    echo "simulation failed"
    exit 1
}
